/* axi_lrsc.f */
+incdir+rtl
+incdir+test
rtl/axi_lrsc_pkg.sv
rtl/axi_lrsc_read_path.sv
rtl/axi_lrsc_write_path.sv
rtl/axi_lrsc_res_table.sv
rtl/axi_lrsc.sv
test/tb_axi_lrsc.sv

/* Bender.yml */
package:
  name: axi_lrsc

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/axi_lrsc_pkg.sv
      - rtl/axi_lrsc_read_path.sv
      - rtl/axi_lrsc_write_path.sv
      - rtl/axi_lrsc_res_table.sv
      - rtl/axi_lrsc.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_axi_lrsc.sv

/* test/tb_axi_lrsc_tests.svh */
// LR/SC directed tests
`ifndef TB_AXI_LRSC_TESTS_SVH
`define TB_AXI_LRSC_TESTS_SVH

// Single-beat read from the upstream side
task automatic read_word(input string test_name, input id_t txn_id, input addr_t txn_addr,
                         input logic excl, output resp_e resp, output data_t data);
    @(posedge clk_i);
    slv_ar_i       <= '{id: txn_id, addr: txn_addr, len: 8'd0, size: 3'd2,
                        burst: BURST_INCR, lock: excl};
    slv_ar_valid_i <= 1'b1;
    do @(posedge clk_i); while (!slv_ar_ready_o);
    // The memory never sees an exclusive read
    check_equal(test_name, 1'b0, mst_ar_o.lock);
    slv_ar_valid_i <= 1'b0;
    slv_r_ready_i  <= 1'b1;
    do @(posedge clk_i); while (!slv_r_valid_o);
    check_equal(test_name, txn_id, slv_r_o.id);
    check_equal(test_name, 1'b1, slv_r_o.last);
    resp = slv_r_o.resp;
    data = slv_r_o.data;
    slv_r_ready_i <= 1'b0;
endtask

// Burst write with full strobes, one beat per queue entry
task automatic write_burst(input string test_name, input id_t txn_id, input addr_t txn_addr,
                           input logic excl, input burst_e burst, input data_t beats[$],
                           output resp_e resp);
    @(posedge clk_i);
    slv_aw_i       <= '{id: txn_id, addr: txn_addr, len: 8'(beats.size() - 1), size: 3'd2,
                        burst: burst, lock: excl};
    slv_aw_valid_i <= 1'b1;
    do @(posedge clk_i); while (!slv_aw_ready_o);
    // The memory never sees an exclusive write
    check_equal(test_name, 1'b0, mst_aw_o.lock);
    slv_aw_valid_i <= 1'b0;
    foreach (beats[i]) begin
        slv_w_i       <= '{data: beats[i], strb: '1, last: (i == beats.size() - 1)};
        slv_w_valid_i <= 1'b1;
        do @(posedge clk_i); while (!slv_w_ready_o);
    end
    slv_w_valid_i <= 1'b0;
    slv_b_ready_i <= 1'b1;
    do @(posedge clk_i); while (!slv_b_valid_o);
    check_equal(test_name, txn_id, slv_b_o.id);
    resp = slv_b_o.resp;
    slv_b_ready_i <= 1'b0;
endtask

task automatic write_word(input string test_name, input id_t txn_id, input addr_t txn_addr,
                          input logic excl, input data_t data, output resp_e resp);
    data_t beats[$];
    beats.push_back(data);
    write_burst(test_name, txn_id, txn_addr, excl, BURST_INCR, beats, resp);
endtask

task automatic test_plain_access();
    string name = "test_plain_access";
    resp_e resp;
    data_t wdata;
    data_t rdata;
    wdata = $urandom();
    write_word(name, 4'd0, 32'h0000_1000, 1'b0, wdata, resp);
    check_equal(name, RESP_OKAY, resp);
    read_word(name, 4'd0, 32'h0000_1000, 1'b0, resp, rdata);
    check_equal(name, RESP_OKAY, resp);
    check_equal(name, wdata, rdata);
endtask

task automatic test_lr_sc_success();
    string name = "test_lr_sc_success";
    resp_e resp;
    data_t wdata;
    data_t rdata;
    wdata = $urandom();
    read_word(name, 4'd1, 32'h0000_1010, 1'b1, resp, rdata);
    check_equal(name, RESP_EXOKAY, resp);
    write_word(name, 4'd1, 32'h0000_1010, 1'b1, wdata, resp);
    check_equal(name, RESP_EXOKAY, resp);
    read_word(name, 4'd1, 32'h0000_1010, 1'b0, resp, rdata);
    check_equal(name, RESP_OKAY, resp);
    check_equal(name, wdata, rdata);
endtask

task automatic test_sc_without_reservation();
    string name = "test_sc_without_reservation";
    resp_e resp;
    data_t old_data;
    data_t rdata;
    old_data = $urandom();
    write_word(name, 4'd2, 32'h0000_1020, 1'b0, old_data, resp);
    check_equal(name, RESP_OKAY, resp);
    // No reservation for CPU 2, so the SC is dropped
    write_word(name, 4'd2, 32'h0000_1020, 1'b1, ~old_data, resp);
    check_equal(name, RESP_OKAY, resp);
    read_word(name, 4'd2, 32'h0000_1020, 1'b0, resp, rdata);
    check_equal(name, old_data, rdata);
endtask

task automatic test_reservation_lost();
    string name = "test_reservation_lost";
    resp_e resp;
    data_t cpu3_data;
    data_t rdata;
    cpu3_data = $urandom();
    read_word(name, 4'd0, 32'h0000_1030, 1'b1, resp, rdata);
    check_equal(name, RESP_EXOKAY, resp);
    write_word(name, 4'd3, 32'h0000_1030, 1'b0, cpu3_data, resp);
    check_equal(name, RESP_OKAY, resp);
    write_word(name, 4'd0, 32'h0000_1030, 1'b1, ~cpu3_data, resp);
    check_equal(name, RESP_OKAY, resp);
    read_word(name, 4'd0, 32'h0000_1030, 1'b0, resp, rdata);
    check_equal(name, cpu3_data, rdata);
endtask

task automatic test_burst_clears();
    string name = "test_burst_clears";
    resp_e resp;
    data_t beats[$];
    data_t rdata;
    beats.push_back($urandom());
    beats.push_back($urandom());
    read_word(name, 4'd1, 32'h0000_1044, 1'b1, resp, rdata);
    check_equal(name, RESP_EXOKAY, resp);
    write_burst(name, 4'd0, 32'h0000_1040, 1'b0, BURST_INCR, beats, resp);
    check_equal(name, RESP_OKAY, resp);
    // Second beat landed on 0x1044 and removed CPU 1's reservation
    write_word(name, 4'd1, 32'h0000_1044, 1'b1, ~beats[1], resp);
    check_equal(name, RESP_OKAY, resp);
    read_word(name, 4'd1, 32'h0000_1044, 1'b0, resp, rdata);
    check_equal(name, beats[1], rdata);
endtask

task automatic test_outside_window();
    string name = "test_outside_window";
    resp_e resp;
    data_t wdata;
    data_t rdata;
    wdata = $urandom();
    read_word(name, 4'd1, 32'h0000_3000, 1'b1, resp, rdata);
    check_equal(name, RESP_OKAY, resp);
    write_word(name, 4'd1, 32'h0000_3000, 1'b1, wdata, resp);
    check_equal(name, RESP_OKAY, resp);
    read_word(name, 4'd1, 32'h0000_3000, 1'b0, resp, rdata);
    check_equal(name, wdata, rdata);
endtask

`endif

/* test/tb_axi_lrsc.sv */
// LR/SC adapter testbench
module tb_axi_lrsc;
    import axi_lrsc_pkg::*;

    // Limit well above the length of the six tests
    localparam int unsigned TIMEOUT_CYCLES = 2000;

    logic     clk_i;
    logic     rst_ni;

    ax_chan_t slv_ar_i;
    ax_chan_t slv_aw_i;
    ax_chan_t mst_ar_o;
    ax_chan_t mst_aw_o;
    w_chan_t  slv_w_i;
    w_chan_t  mst_w_o;
    r_chan_t  slv_r_o;
    r_chan_t  mst_r_i;
    b_chan_t  slv_b_o;
    b_chan_t  mst_b_i;

    logic slv_ar_valid_i, slv_ar_ready_o, slv_aw_valid_i, slv_aw_ready_o;
    logic slv_w_valid_i, slv_w_ready_o, slv_r_valid_o, slv_r_ready_i;
    logic slv_b_valid_o, slv_b_ready_i;
    logic mst_ar_valid_o, mst_ar_ready_i, mst_aw_valid_o, mst_aw_ready_i;
    logic mst_w_valid_o, mst_w_ready_i, mst_r_valid_i, mst_r_ready_o;
    logic mst_b_valid_i, mst_b_ready_o;

    int unsigned cycle_count = 0;

    // Downstream memory with one entry per 32-bit word
    data_t  mem[addr_t];
    addr_t  wr_addr;
    burst_e wr_burst;

    axi_lrsc i_axi_lrsc (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic data_t read_mem(input addr_t addr);
        return mem.exists(addr >> 2) ? mem[addr >> 2] : '0;
    endfunction

    function automatic void write_mem(input addr_t addr, input data_t data, input strb_t strb);
        data_t word;
        word = read_mem(addr);
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (strb[b]) begin
                word[8*b +: 8] = data[8*b +: 8];
            end
        end
        mem[addr >> 2] = word;
    endfunction

    // Memory slave that is always ready and answers OKAY a cycle after each request
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mst_r_i       <= '0;
            mst_r_valid_i <= 1'b0;
            mst_b_i       <= '0;
            mst_b_valid_i <= 1'b0;
        end else begin
            if (mst_ar_valid_o && mst_ar_ready_i) begin
                mst_r_i       <= '{id: mst_ar_o.id, data: read_mem(mst_ar_o.addr),
                                   resp: RESP_OKAY, last: 1'b1};
                mst_r_valid_i <= 1'b1;
            end else if (mst_r_valid_i && mst_r_ready_o) begin
                mst_r_valid_i <= 1'b0;
            end
            if (mst_aw_valid_o && mst_aw_ready_i) begin
                wr_addr  <= mst_aw_o.addr;
                wr_burst <= mst_aw_o.burst;
                mst_b_i  <= '{id: mst_aw_o.id, resp: RESP_OKAY};
            end
            if (mst_w_valid_o && mst_w_ready_i) begin
                write_mem(wr_addr, mst_w_o.data, mst_w_o.strb);
                if (wr_burst != BURST_FIXED) begin
                    wr_addr <= wr_addr + 32'd4;
                end
                if (mst_w_o.last) begin
                    mst_b_valid_i <= 1'b1;
                end
            end
            if (mst_b_valid_i && mst_b_ready_o) begin
                mst_b_valid_i <= 1'b0;
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles without finishing the tests", cycle_count);
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic check_equal(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %h, actual %h", test_name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    `include "tb_axi_lrsc_tests.svh"

    initial begin
        int unsigned seed_ret;
        seed_ret = $urandom(32'hfb08_7b0c);
        rst_ni         <= 1'b0;
        slv_ar_i       <= '0;
        slv_ar_valid_i <= 1'b0;
        slv_aw_i       <= '0;
        slv_aw_valid_i <= 1'b0;
        slv_w_i        <= '0;
        slv_w_valid_i  <= 1'b0;
        slv_r_ready_i  <= 1'b0;
        slv_b_ready_i  <= 1'b0;
        mst_ar_ready_i <= 1'b1;
        mst_aw_ready_i <= 1'b1;
        mst_w_ready_i  <= 1'b1;
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;

        test_plain_access();
        test_lr_sc_success();
        test_sc_without_reservation();
        test_reservation_lost();
        test_burst_clears();
        test_outside_window();

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* rtl/axi_lrsc.sv */
// AXI LR/SC adapter
module axi_lrsc (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // Upstream master side
    input  axi_lrsc_pkg::ax_chan_t slv_ar_i,
    input  logic                   slv_ar_valid_i,
    output logic                   slv_ar_ready_o,
    input  axi_lrsc_pkg::ax_chan_t slv_aw_i,
    input  logic                   slv_aw_valid_i,
    output logic                   slv_aw_ready_o,
    input  axi_lrsc_pkg::w_chan_t  slv_w_i,
    input  logic                   slv_w_valid_i,
    output logic                   slv_w_ready_o,
    output axi_lrsc_pkg::r_chan_t  slv_r_o,
    output logic                   slv_r_valid_o,
    input  logic                   slv_r_ready_i,
    output axi_lrsc_pkg::b_chan_t  slv_b_o,
    output logic                   slv_b_valid_o,
    input  logic                   slv_b_ready_i,
    // Downstream memory side
    output axi_lrsc_pkg::ax_chan_t mst_ar_o,
    output logic                   mst_ar_valid_o,
    input  logic                   mst_ar_ready_i,
    output axi_lrsc_pkg::ax_chan_t mst_aw_o,
    output logic                   mst_aw_valid_o,
    input  logic                   mst_aw_ready_i,
    output axi_lrsc_pkg::w_chan_t  mst_w_o,
    output logic                   mst_w_valid_o,
    input  logic                   mst_w_ready_i,
    input  axi_lrsc_pkg::r_chan_t  mst_r_i,
    input  logic                   mst_r_valid_i,
    output logic                   mst_r_ready_o,
    input  axi_lrsc_pkg::b_chan_t  mst_b_i,
    input  logic                   mst_b_valid_i,
    output logic                   mst_b_ready_o
);
    import axi_lrsc_pkg::*;

    res_set_t   res_set;
    logic       res_set_valid;
    res_check_t res_check;
    logic       res_hit;
    addr_t      res_clr_addr;
    logic       res_clr_valid;

    axi_lrsc_read_path i_read_path (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .slv_ar_i        (slv_ar_i),
        .slv_ar_valid_i  (slv_ar_valid_i),
        .slv_ar_ready_o  (slv_ar_ready_o),
        .mst_ar_o        (mst_ar_o),
        .mst_ar_valid_o  (mst_ar_valid_o),
        .mst_ar_ready_i  (mst_ar_ready_i),
        .mst_r_i         (mst_r_i),
        .mst_r_valid_i   (mst_r_valid_i),
        .mst_r_ready_o   (mst_r_ready_o),
        .slv_r_o         (slv_r_o),
        .slv_r_valid_o   (slv_r_valid_o),
        .slv_r_ready_i   (slv_r_ready_i),
        .res_set_o       (res_set),
        .res_set_valid_o (res_set_valid)
    );

    axi_lrsc_write_path i_write_path (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .slv_aw_i        (slv_aw_i),
        .slv_aw_valid_i  (slv_aw_valid_i),
        .slv_aw_ready_o  (slv_aw_ready_o),
        .mst_aw_o        (mst_aw_o),
        .mst_aw_valid_o  (mst_aw_valid_o),
        .mst_aw_ready_i  (mst_aw_ready_i),
        .slv_w_i         (slv_w_i),
        .slv_w_valid_i   (slv_w_valid_i),
        .slv_w_ready_o   (slv_w_ready_o),
        .mst_w_o         (mst_w_o),
        .mst_w_valid_o   (mst_w_valid_o),
        .mst_w_ready_i   (mst_w_ready_i),
        .mst_b_i         (mst_b_i),
        .mst_b_valid_i   (mst_b_valid_i),
        .mst_b_ready_o   (mst_b_ready_o),
        .slv_b_o         (slv_b_o),
        .slv_b_valid_o   (slv_b_valid_o),
        .slv_b_ready_i   (slv_b_ready_i),
        .res_check_o     (res_check),
        .res_hit_i       (res_hit),
        .res_clr_addr_o  (res_clr_addr),
        .res_clr_valid_o (res_clr_valid)
    );

    axi_lrsc_res_table i_res_table (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .res_set_i       (res_set),
        .res_set_valid_i (res_set_valid),
        .res_check_i     (res_check),
        .res_hit_o       (res_hit),
        .res_clr_addr_i  (res_clr_addr),
        .res_clr_valid_i (res_clr_valid)
    );

endmodule

/* rtl/axi_lrsc_res_table.sv */
// LR/SC reservation table
`include "axi_lrsc_params.svh"

module axi_lrsc_res_table (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // Place a reservation
    input  axi_lrsc_pkg::res_set_t   res_set_i,
    input  logic                     res_set_valid_i,
    // Test a reservation
    input  axi_lrsc_pkg::res_check_t res_check_i,
    output logic                     res_hit_o,
    // Drop all reservations on an address
    input  axi_lrsc_pkg::addr_t      res_clr_addr_i,
    input  logic                     res_clr_valid_i
);
    import axi_lrsc_pkg::*;

    logic [`AXI_LRSC_NUM_CPUS-1:0] valid_d, valid_q;
    addr_t                         addr_d[`AXI_LRSC_NUM_CPUS];
    addr_t                         addr_q[`AXI_LRSC_NUM_CPUS];

    always_comb begin
        valid_d = valid_q;
        addr_d  = addr_q;

        // Clear goes first
        if (res_clr_valid_i) begin
            for (int i = 0; i < `AXI_LRSC_NUM_CPUS; i++) begin
                if (addr_q[i] == res_clr_addr_i) begin
                    valid_d[i] = 1'b0;
                end
            end
        end

        // So a set in the same cycle survives
        if (res_set_valid_i) begin
            valid_d[res_set_i.cpu] = 1'b1;
            addr_d[res_set_i.cpu]  = res_set_i.addr;
        end
    end

    // Combinational lookup of the checking CPU's entry
    assign res_hit_o = valid_q[res_check_i.cpu] &&
                       (addr_q[res_check_i.cpu] == res_check_i.addr);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    // Reserved address of each CPU
    always_ff @(posedge clk_i) begin
        addr_q <= addr_d;
    end

endmodule

/* rtl/axi_lrsc_write_path.sv */
// AXI LR/SC write path
`include "axi_lrsc_params.svh"

module axi_lrsc_write_path (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // Upstream AW
    input  axi_lrsc_pkg::ax_chan_t   slv_aw_i,
    input  logic                     slv_aw_valid_i,
    output logic                     slv_aw_ready_o,
    // Downstream AW
    output axi_lrsc_pkg::ax_chan_t   mst_aw_o,
    output logic                     mst_aw_valid_o,
    input  logic                     mst_aw_ready_i,
    // Upstream W
    input  axi_lrsc_pkg::w_chan_t    slv_w_i,
    input  logic                     slv_w_valid_i,
    output logic                     slv_w_ready_o,
    // Downstream W
    output axi_lrsc_pkg::w_chan_t    mst_w_o,
    output logic                     mst_w_valid_o,
    input  logic                     mst_w_ready_i,
    // Downstream B
    input  axi_lrsc_pkg::b_chan_t    mst_b_i,
    input  logic                     mst_b_valid_i,
    output logic                     mst_b_ready_o,
    // Upstream B
    output axi_lrsc_pkg::b_chan_t    slv_b_o,
    output logic                     slv_b_valid_o,
    input  logic                     slv_b_ready_i,
    // Reservation check and clear
    output axi_lrsc_pkg::res_check_t res_check_o,
    input  logic                     res_hit_i,
    output axi_lrsc_pkg::addr_t      res_clr_addr_o,
    output logic                     res_clr_valid_o
);
    import axi_lrsc_pkg::*;

    typedef enum logic [2:0] {
        AW_IDLE,
        W_FORWARD,
        W_BYPASS,
        W_DROP,
        B_FORWARD,
        B_INJECT
    } w_state_e;

    w_state_e state_d, state_q;
    logic     excl_d, excl_q;
    addr_t    addr_d, addr_q;
    burst_e   burst_d, burst_q;
    id_t      id_d, id_q;
    logic     aw_in_win;
    logic     aw_excl;

    assign aw_in_win = in_excl_window(slv_aw_i.addr);
    assign aw_excl   = aw_in_win && slv_aw_i.lock && (slv_aw_i.len == 8'd0);

    // Check is side-effect free, so it is always presented
    assign res_check_o.cpu  = cpu_of(slv_aw_i.id);
    assign res_check_o.addr = slv_aw_i.addr;
    assign res_clr_addr_o   = addr_q;

    assign mst_w_o = slv_w_i;

    always_comb begin
        state_d         = state_q;
        excl_d          = excl_q;
        addr_d          = addr_q;
        burst_d         = burst_q;
        id_d            = id_q;
        mst_aw_o        = slv_aw_i;
        mst_aw_o.lock   = 1'b0;
        mst_aw_valid_o  = 1'b0;
        slv_aw_ready_o  = 1'b0;
        mst_w_valid_o   = 1'b0;
        slv_w_ready_o   = 1'b0;
        mst_b_ready_o   = 1'b0;
        slv_b_valid_o   = 1'b0;
        slv_b_o         = mst_b_i;
        slv_b_o.resp    = rewrite_resp(mst_b_i.resp, excl_q);
        res_clr_valid_o = 1'b0;

        case (state_q)
            AW_IDLE: begin
                if (slv_aw_valid_i) begin
                    if (aw_excl && !res_hit_i) begin
                        // Failed SC is swallowed here and answered locally
                        slv_aw_ready_o = 1'b1;
                        excl_d         = 1'b0;
                        state_d        = W_DROP;
                    end else begin
                        mst_aw_valid_o = 1'b1;
                        slv_aw_ready_o = mst_aw_ready_i;
                        if (mst_aw_ready_i) begin
                            excl_d  = aw_excl;
                            state_d = aw_in_win ? W_FORWARD : W_BYPASS;
                        end
                    end
                    if (slv_aw_ready_o) begin
                        addr_d  = slv_aw_i.addr;
                        burst_d = slv_aw_i.burst;
                        id_d    = slv_aw_i.id;
                    end
                end
            end

            W_FORWARD: begin
                mst_w_valid_o = slv_w_valid_i;
                slv_w_ready_o = mst_w_ready_i;
                if (slv_w_valid_i && mst_w_ready_i) begin
                    // Any write to a reserved word kills the reservation
                    res_clr_valid_o = 1'b1;
                    if (burst_q != BURST_FIXED) begin
                        addr_d = addr_q + addr_t'(`AXI_LRSC_DATA_WIDTH / 8);
                    end
                    if (slv_w_i.last) begin
                        state_d = B_FORWARD;
                    end
                end
            end

            W_BYPASS: begin
                mst_w_valid_o = slv_w_valid_i;
                slv_w_ready_o = mst_w_ready_i;
                if (slv_w_valid_i && mst_w_ready_i && slv_w_i.last) begin
                    state_d = B_FORWARD;
                end
            end

            W_DROP: begin
                slv_w_ready_o = 1'b1;
                if (slv_w_valid_i && slv_w_i.last) begin
                    state_d = B_INJECT;
                end
            end

            B_FORWARD: begin
                mst_b_ready_o = slv_b_ready_i;
                slv_b_valid_o = mst_b_valid_i;
                if (mst_b_valid_i && slv_b_ready_i) begin
                    excl_d  = 1'b0;
                    state_d = AW_IDLE;
                end
            end

            B_INJECT: begin
                slv_b_valid_o = 1'b1;
                slv_b_o.id    = id_q;
                slv_b_o.resp  = RESP_OKAY;
                if (slv_b_ready_i) begin
                    state_d = AW_IDLE;
                end
            end

            default: state_d = AW_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= AW_IDLE;
            excl_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            excl_q  <= excl_d;
        end
    end

    // Beat address, burst type and id of the current write
    always_ff @(posedge clk_i) begin
        addr_q  <= addr_d;
        burst_q <= burst_d;
        id_q    <= id_d;
    end

endmodule

/* rtl/axi_lrsc_read_path.sv */
// AXI LR/SC read path
module axi_lrsc_read_path (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // Upstream AR
    input  axi_lrsc_pkg::ax_chan_t slv_ar_i,
    input  logic                   slv_ar_valid_i,
    output logic                   slv_ar_ready_o,
    // Downstream AR
    output axi_lrsc_pkg::ax_chan_t mst_ar_o,
    output logic                   mst_ar_valid_o,
    input  logic                   mst_ar_ready_i,
    // Downstream R
    input  axi_lrsc_pkg::r_chan_t  mst_r_i,
    input  logic                   mst_r_valid_i,
    output logic                   mst_r_ready_o,
    // Upstream R
    output axi_lrsc_pkg::r_chan_t  slv_r_o,
    output logic                   slv_r_valid_o,
    input  logic                   slv_r_ready_i,
    // Reservation placement
    output axi_lrsc_pkg::res_set_t res_set_o,
    output logic                   res_set_valid_o
);
    import axi_lrsc_pkg::*;

    typedef enum logic [1:0] {
        R_IDLE,
        R_WAIT_AR,
        R_WAIT_R
    } r_state_e;

    r_state_e state_d, state_q;
    logic     excl_d, excl_q;
    logic     ar_excl;

    // Single-beat exclusive read inside the window
    assign ar_excl = slv_ar_i.lock && (slv_ar_i.len == 8'd0) && in_excl_window(slv_ar_i.addr);

    assign res_set_o.cpu  = cpu_of(slv_ar_i.id);
    assign res_set_o.addr = slv_ar_i.addr;

    always_comb begin
        state_d         = state_q;
        excl_d          = excl_q;
        mst_ar_o        = slv_ar_i;
        mst_ar_o.lock   = 1'b0;
        mst_ar_valid_o  = 1'b0;
        slv_ar_ready_o  = 1'b0;
        mst_r_ready_o   = 1'b0;
        slv_r_valid_o   = 1'b0;
        slv_r_o         = mst_r_i;
        slv_r_o.resp    = rewrite_resp(mst_r_i.resp, excl_q);
        res_set_valid_o = 1'b0;

        case (state_q)
            R_IDLE, R_WAIT_AR: begin
                mst_ar_valid_o = slv_ar_valid_i;
                slv_ar_ready_o = mst_ar_ready_i;
                if (slv_ar_valid_i && mst_ar_ready_i) begin
                    // Reservation is placed together with the AR transfer
                    res_set_valid_o = ar_excl;
                    excl_d          = ar_excl;
                    state_d         = R_WAIT_R;
                end else if (slv_ar_valid_i) begin
                    state_d = R_WAIT_AR;
                end
            end

            R_WAIT_R: begin
                mst_r_ready_o = slv_r_ready_i;
                slv_r_valid_o = mst_r_valid_i;
                if (mst_r_valid_i && slv_r_ready_i && mst_r_i.last) begin
                    excl_d  = 1'b0;
                    state_d = R_IDLE;
                end
            end

            default: state_d = R_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= R_IDLE;
            excl_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            excl_q  <= excl_d;
        end
    end

endmodule

/* rtl/axi_lrsc_pkg.sv */
// AXI LR/SC adapter types
`include "axi_lrsc_params.svh"

package axi_lrsc_pkg;

    typedef logic [`AXI_LRSC_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`AXI_LRSC_DATA_WIDTH-1:0]   data_t;
    typedef logic [`AXI_LRSC_STRB_WIDTH-1:0]   strb_t;
    typedef logic [`AXI_LRSC_ID_WIDTH-1:0]     id_t;
    typedef logic [`AXI_LRSC_CPU_ID_WIDTH-1:0] cpu_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_e;

    // Shared by AR and AW
    typedef struct packed {
        id_t        id;
        addr_t      addr;
        logic [7:0] len;
        logic [2:0] size;
        burst_e     burst;
        logic       lock;
    } ax_chan_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } w_chan_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        resp_e resp;
        logic  last;
    } r_chan_t;

    typedef struct packed {
        id_t   id;
        resp_e resp;
    } b_chan_t;

    typedef struct packed {
        cpu_t  cpu;
        addr_t addr;
    } res_set_t;

    typedef struct packed {
        cpu_t  cpu;
        addr_t addr;
    } res_check_t;

    function automatic logic in_excl_window(input addr_t addr);
        return (addr >= `AXI_LRSC_ADDR_BEGIN) && (addr <= `AXI_LRSC_ADDR_END);
    endfunction

    // Reservations are kept per CPU, named by the low id bits
    function automatic cpu_t cpu_of(input id_t id);
        return id[`AXI_LRSC_CPU_ID_WIDTH-1:0];
    endfunction

    // OKAY turns into EXOKAY for a successful exclusive access, errors pass
    function automatic resp_e rewrite_resp(input resp_e resp, input logic excl);
        if (resp == RESP_OKAY) begin
            return excl ? RESP_EXOKAY : RESP_OKAY;
        end
        return resp;
    endfunction

endpackage

/* rtl/axi_lrsc_params.svh */
// AXI LR/SC adapter parameters
`ifndef AXI_LRSC_PARAMS_SVH
`define AXI_LRSC_PARAMS_SVH

// AXI channel widths
`define AXI_LRSC_ADDR_WIDTH 32
`define AXI_LRSC_DATA_WIDTH 32
`define AXI_LRSC_ID_WIDTH 4

// Byte strobe width follows the data width
`define AXI_LRSC_STRB_WIDTH (`AXI_LRSC_DATA_WIDTH / 8)

// CPUs that may hold a reservation
`define AXI_LRSC_NUM_CPUS 4

// CPU index taken from the low bits of the AXI id
`define AXI_LRSC_CPU_ID_WIDTH 2

// Closed address window with LR/SC support
`define AXI_LRSC_ADDR_BEGIN 32'h0000_1000
`define AXI_LRSC_ADDR_END 32'h0000_1FFF

`endif
